// ==== design/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	localparam int XLEN         = 32;
	localparam int FETCH_WIDTH  = 5;
	localparam int NUM_REPLICAS = 3;
	localparam int CORR_CNT_W   = 8;

	//////////////////////////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////////////////////////

	// One instruction address
	typedef logic [XLEN-1:0] pc_t;

	// One bit per slot of a fetch group
	typedef logic [FETCH_WIDTH-1:0] slot_mask_t;

	// One bit per PC replica
	typedef logic [NUM_REPLICAS-1:0] replica_mask_t;

	//////////////////////////////////////////////////////////////////////
	// Address constants
	//////////////////////////////////////////////////////////////////////

	localparam pc_t RESET_PC   = 32'h8000_0000;

	// Five 4-byte instructions per group
	localparam pc_t GROUP_INCR = 32'd20;
	localparam pc_t INSN_BYTES = 32'd4;

endpackage

`default_nettype wire

// ==== design/tmr_voter.sv ====
`default_nettype none

module tmr_voter (
	input  logic                    secure_mode_i,
	input  fetch_pkg::pc_t          data_0_i,
	input  fetch_pkg::pc_t          data_1_i,
	input  fetch_pkg::pc_t          data_2_i,
	output fetch_pkg::pc_t          data_o,
	output logic                    mismatch_o,
	output fetch_pkg::replica_mask_t error_o,
	output logic                    fatal_o
);

	import fetch_pkg::*;

	pc_t majority;

	always_comb begin
		// Bitwise two-out-of-three
		majority = (data_0_i & data_1_i) | (data_1_i & data_2_i) | (data_0_i & data_2_i);

		// Non-secure default: replica 0 only, no checking
		data_o     = data_0_i;
		error_o    = '0;
		mismatch_o = 1'b0;
		fatal_o    = 1'b0;

		if (secure_mode_i) begin
			data_o     = majority;
			error_o[0] = (data_0_i != majority);
			error_o[1] = (data_1_i != majority);
			error_o[2] = (data_2_i != majority);
			mismatch_o = |error_o;
			// No two replicas agree, the vote is meaningless
			fatal_o    = (data_0_i != data_1_i) && (data_1_i != data_2_i) &&
				(data_0_i != data_2_i);
		end

		// Pairwise disagreement must leave at least one replica off the majority
		if (fatal_o) begin
			a_fatal_has_mismatch: assert (mismatch_o)
				else $error("tmr_voter: fatal without mismatch");
		end
	end

endmodule

`default_nettype wire

// ==== design/pc_target_select.sv ====
`default_nettype none

module pc_target_select (
	input  fetch_pkg::pc_t       pc_i,
	input  fetch_pkg::pc_t       slot_pc_i [fetch_pkg::FETCH_WIDTH],
	input  fetch_pkg::slot_mask_t jump_i,
	input  fetch_pkg::slot_mask_t jalr_i,
	input  fetch_pkg::pc_t       imm_i [fetch_pkg::FETCH_WIDTH],
	input  logic                 pred_valid_i,
	input  fetch_pkg::pc_t       pred_target_i,
	output logic                 redirect_o,
	output fetch_pkg::pc_t       target_o,
	output fetch_pkg::pc_t       pc_save_o [fetch_pkg::FETCH_WIDTH]
);

	import fetch_pkg::*;

	pc_t        imm_aligned [FETCH_WIDTH];
	pc_t        jump_tgt    [FETCH_WIDTH];
	pc_t        jalr_tgt    [FETCH_WIDTH];
	pc_t        link_val    [FETCH_WIDTH];
	slot_mask_t cf_slot;
	logic       sel_is_jump;
	pc_t        sel_pc;

	assign cf_slot = jump_i | jalr_i;

	//////////////////////////////////////////////////////////////////////
	// Per-slot candidates
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int k = 0; k < FETCH_WIDTH; k++) begin
			// Low two immediate bits dropped to keep targets word aligned
			imm_aligned[k] = {imm_i[k][XLEN-1:2], 2'b00};
			jump_tgt[k]    = slot_pc_i[k] + imm_aligned[k];

			// Without a prediction fall through past the jalr
			jalr_tgt[k] = pred_valid_i ? pred_target_i : slot_pc_i[k] + INSN_BYTES;

			// Return address of slot k
			link_val[k] = pc_i + pc_t'(INSN_BYTES * (k + 1));

			// Link for jal/jalr, auipc result otherwise
			pc_save_o[k] = cf_slot[k] ? link_val[k] : jump_tgt[k];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// First control-flow slot wins
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		redirect_o  = 1'b0;
		target_o    = '0;
		sel_is_jump = 1'b0;
		sel_pc      = pc_i;

		// Walk from the last slot so the earliest one overrides
		for (int k = FETCH_WIDTH - 1; k >= 0; k--) begin
			if (cf_slot[k]) begin
				redirect_o  = 1'b1;
				sel_pc      = slot_pc_i[k];
				sel_is_jump = !jalr_i[k];
				target_o    = jalr_i[k] ? jalr_tgt[k] : jump_tgt[k];
			end
		end

		if (redirect_o && sel_is_jump && (sel_pc[1:0] == 2'b00)) begin
			a_jump_aligned: assert (target_o[1:0] == 2'b00)
				else $error("pc_target_select: misaligned jump target %h", target_o);
		end
	end

endmodule

`default_nettype wire

// ==== design/pc_ctrl_super.sv ====
`default_nettype none

module pc_ctrl_super (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    bubble_i,
	input  logic                    secure_mode_i,
	input  logic                    misprediction_i,
	input  fetch_pkg::slot_mask_t    jump_i,
	input  fetch_pkg::slot_mask_t    jalr_i,
	input  fetch_pkg::pc_t          imm_i [fetch_pkg::FETCH_WIDTH],
	input  logic                    pred_valid_i,
	input  fetch_pkg::pc_t          pred_target_i,
	input  fetch_pkg::pc_t          correct_pc_i,
	input  logic                    inject_i,
	input  logic [1:0]              inject_sel_i,
	input  fetch_pkg::pc_t          inject_mask_i,
	output fetch_pkg::pc_t          inst_addr_o  [fetch_pkg::FETCH_WIDTH],
	output fetch_pkg::pc_t          current_pc_o [fetch_pkg::FETCH_WIDTH],
	output fetch_pkg::pc_t          pc_save_o    [fetch_pkg::FETCH_WIDTH],
	output logic                    mismatch_o,
	output fetch_pkg::replica_mask_t error_o,
	output logic                    fatal_o
);

	import fetch_pkg::*;

	pc_t  pc_rep [NUM_REPLICAS];
	pc_t  pc_voted;
	pc_t  pc_next;
	pc_t  target;
	pc_t  slot_pc [FETCH_WIDTH];
	logic redirect;
	logic update;
	logic heal;

	tmr_voter u_voter (
		.secure_mode_i (secure_mode_i),
		.data_0_i      (pc_rep[0]),
		.data_1_i      (pc_rep[1]),
		.data_2_i      (pc_rep[2]),
		.data_o        (pc_voted),
		.mismatch_o    (mismatch_o),
		.error_o       (error_o),
		.fatal_o       (fatal_o)
	);

	pc_target_select u_target (
		.pc_i          (pc_voted),
		.slot_pc_i     (slot_pc),
		.jump_i        (jump_i),
		.jalr_i        (jalr_i),
		.imm_i         (imm_i),
		.pred_valid_i  (pred_valid_i),
		.pred_target_i (pred_target_i),
		.redirect_o    (redirect),
		.target_o      (target),
		.pc_save_o     (pc_save_o)
	);

	//////////////////////////////////////////////////////////////////////
	// Next PC and update control
	//////////////////////////////////////////////////////////////////////

	assign pc_next = misprediction_i ? correct_pc_i :
		redirect ? target : pc_voted + GROUP_INCR;

	// Misprediction overrides a bubble
	assign update = !bubble_i || misprediction_i;
	// Stalled with one replica drifted so rewrite from the vote
	assign heal   = secure_mode_i && mismatch_o;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int r = 0; r < NUM_REPLICAS; r++) begin
				pc_rep[r] <= RESET_PC;
			end
		end else begin
			for (int r = 0; r < NUM_REPLICAS; r++) begin
				// Lab fault injection beats the normal write
				if (inject_i && (inject_sel_i == 2'(r))) begin
					pc_rep[r] <= pc_rep[r] ^ inject_mask_i;
				end else if (update) begin
					pc_rep[r] <= pc_next;
				end else if (heal) begin
					pc_rep[r] <= pc_voted;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Fetch addresses and slot PCs
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		inst_addr_o[0] = !reset ? RESET_PC : (update ? pc_next : pc_voted);
		for (int k = 1; k < FETCH_WIDTH; k++) begin
			inst_addr_o[k] = inst_addr_o[0] + pc_t'(k * INSN_BYTES);
		end
	end

	// Secure mode runs the same PC in all slots
	always_comb begin
		for (int k = 0; k < FETCH_WIDTH; k++) begin
			slot_pc[k]      = secure_mode_i ? pc_voted : pc_voted + pc_t'(k * INSN_BYTES);
			current_pc_o[k] = slot_pc[k];
		end
	end

	a_replicas_agree: assert property (@(posedge clk) disable iff (!reset)
		((update || heal) && !inject_i) |=>
			((pc_rep[0] == pc_rep[1]) && (pc_rep[1] == pc_rep[2])))
		else $error("pc_ctrl_super: replicas differ after a clean write");

endmodule

`default_nettype wire

// ==== design/tmr_fault_monitor.sv ====
`default_nettype none

module tmr_fault_monitor (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          clear_i,
	input  logic                          secure_mode_i,
	input  logic                          mismatch_i,
	input  fetch_pkg::replica_mask_t       error_i,
	input  logic                          fatal_i,
	output fetch_pkg::replica_mask_t       sticky_error_o,
	output logic                          sticky_fatal_o,
	output logic [fetch_pkg::CORR_CNT_W-1:0] correction_count_o
);

	import fetch_pkg::*;

	localparam logic [CORR_CNT_W-1:0] CNT_MAX = '1;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			sticky_error_o     <= '0;
			sticky_fatal_o     <= 1'b0;
			correction_count_o <= '0;
		end else if (clear_i) begin
			sticky_error_o     <= '0;
			sticky_fatal_o     <= 1'b0;
			correction_count_o <= '0;
		end else if (secure_mode_i) begin
			sticky_error_o <= sticky_error_o | error_i;
			if (fatal_i) begin
				sticky_fatal_o <= 1'b1;
			end
			// One count per cycle the voter had to repair
			if (mismatch_i && (correction_count_o != CNT_MAX)) begin
				correction_count_o <= correction_count_o + CORR_CNT_W'(1);
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/fetch_pc_unit.sv ====
`default_nettype none

module fetch_pc_unit (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          bubble_i,
	input  logic                          secure_mode_i,
	input  logic                          misprediction_i,
	input  fetch_pkg::slot_mask_t          jump_i,
	input  fetch_pkg::slot_mask_t          jalr_i,
	input  fetch_pkg::pc_t                imm_i [fetch_pkg::FETCH_WIDTH],
	input  logic                          pred_valid_i,
	input  fetch_pkg::pc_t                pred_target_i,
	input  fetch_pkg::pc_t                correct_pc_i,
	input  logic                          inject_i,
	input  logic [1:0]                    inject_sel_i,
	input  fetch_pkg::pc_t                inject_mask_i,
	input  logic                          clear_i,
	output fetch_pkg::pc_t                inst_addr_o  [fetch_pkg::FETCH_WIDTH],
	output fetch_pkg::pc_t                current_pc_o [fetch_pkg::FETCH_WIDTH],
	output fetch_pkg::pc_t                pc_save_o    [fetch_pkg::FETCH_WIDTH],
	output fetch_pkg::replica_mask_t       sticky_error_o,
	output logic                          sticky_fatal_o,
	output logic [fetch_pkg::CORR_CNT_W-1:0] correction_count_o
);

	import fetch_pkg::*;

	// Voter status toward the monitor
	logic          mismatch;
	replica_mask_t error;
	logic          fatal;

	pc_ctrl_super u_pc_ctrl (
		.clk             (clk),
		.reset           (reset),
		.bubble_i        (bubble_i),
		.secure_mode_i   (secure_mode_i),
		.misprediction_i (misprediction_i),
		.jump_i          (jump_i),
		.jalr_i          (jalr_i),
		.imm_i           (imm_i),
		.pred_valid_i    (pred_valid_i),
		.pred_target_i   (pred_target_i),
		.correct_pc_i    (correct_pc_i),
		.inject_i        (inject_i),
		.inject_sel_i    (inject_sel_i),
		.inject_mask_i   (inject_mask_i),
		.inst_addr_o     (inst_addr_o),
		.current_pc_o    (current_pc_o),
		.pc_save_o       (pc_save_o),
		.mismatch_o      (mismatch),
		.error_o         (error),
		.fatal_o         (fatal)
	);

	tmr_fault_monitor u_fault_mon (
		.clk                (clk),
		.reset              (reset),
		.clear_i            (clear_i),
		.secure_mode_i      (secure_mode_i),
		.mismatch_i         (mismatch),
		.error_i            (error),
		.fatal_i            (fatal),
		.sticky_error_o     (sticky_error_o),
		.sticky_fatal_o     (sticky_fatal_o),
		.correction_count_o (correction_count_o)
	);

endmodule

`default_nettype wire

// ==== sim/tb_fetch_pc.sv ====
`default_nettype none

module tb_fetch_pc;

	import fetch_pkg::*;

	// Data line layout with all fields in hex
	//   0..5   reset, bubble, secure, mispredict, jump mask, jalr mask
	//   6..10  immediates of slots 0..4
	//   11..17 pred_valid, pred_target, correct_pc, inject, inject_sel, inject_mask, clear
	//   18..22 expected addr 0, slot 0 PC, sticky errors, sticky fatal, correction count
	localparam int NUM_FIELDS = 23;
	localparam int F_IMM      = 6;
	localparam int F_EXP      = 18;
	localparam int MAX_VEC    = 64;
	localparam int LINE_BYTES = 160;
	localparam int CLK_PERIOD = 4;

	logic                  clk;
	logic                  reset;
	logic                  bubble_i;
	logic                  secure_mode_i;
	logic                  misprediction_i;
	slot_mask_t            jump_i;
	slot_mask_t            jalr_i;
	pc_t                   imm_i [FETCH_WIDTH];
	logic                  pred_valid_i;
	pc_t                   pred_target_i;
	pc_t                   correct_pc_i;
	logic                  inject_i;
	logic [1:0]            inject_sel_i;
	pc_t                   inject_mask_i;
	logic                  clear_i;
	pc_t                   inst_addr_o  [FETCH_WIDTH];
	pc_t                   current_pc_o [FETCH_WIDTH];
	pc_t                   pc_save_o    [FETCH_WIDTH];
	replica_mask_t         sticky_error_o;
	logic                  sticky_fatal_o;
	logic [CORR_CNT_W-1:0] correction_count_o;

	pc_t  vec [MAX_VEC][NUM_FIELDS];
	int   num_vec;
	logic vec_ready;

	fetch_pc_unit UUT (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Spare cycles on top of one clock per data line
	initial begin
		wait (vec_ready);
		#((num_vec + 10) * CLK_PERIOD);
		$display("Timeout: the data lines were not all applied in time");
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic report_mismatch(input string name, input string exp_s,
		input string act_s);
		$display("MISMATCH t=%0t %s expected %s got %s", $time, name, exp_s, act_s);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_pc(input string name, input pc_t exp_v, input pc_t act_v);
		if (act_v !== exp_v) begin
			report_mismatch(name, $sformatf("%h", exp_v), $sformatf("%h", act_v));
		end
	endtask

	task automatic check_mask(input string name, input replica_mask_t exp_v,
		input replica_mask_t act_v);
		if (act_v !== exp_v) begin
			report_mismatch(name, $sformatf("%h", exp_v), $sformatf("%h", act_v));
		end
	endtask

	task automatic check_flag(input string name, input logic exp_v, input logic act_v);
		if (act_v !== exp_v) begin
			report_mismatch(name, $sformatf("%h", exp_v), $sformatf("%h", act_v));
		end
	endtask

	task automatic check_count(input string name, input logic [CORR_CNT_W-1:0] exp_v,
		input logic [CORR_CNT_W-1:0] act_v);
		if (act_v !== exp_v) begin
			report_mismatch(name, $sformatf("%h", exp_v), $sformatf("%h", act_v));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Vector file, drive and check
	//////////////////////////////////////////////////////////////////////

	task automatic load_vectors();
		int                      fd;
		int                      n_read;
		logic [8*LINE_BYTES-1:0] line_buf;
		fd = $fopen("sim/fetch_pc_testdata.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the data file sim/fetch_pc_testdata.txt");
			$display("SOME TESTS FAILED");
			$fatal(1, "missing data file");
		end else begin
			num_vec  = 0;
			line_buf = '0;
			while ((num_vec < MAX_VEC) && ($fgets(line_buf, fd) > 0)) begin
				n_read = $sscanf(line_buf,
					"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					vec[num_vec][0], vec[num_vec][1], vec[num_vec][2], vec[num_vec][3],
					vec[num_vec][4], vec[num_vec][5], vec[num_vec][6], vec[num_vec][7],
					vec[num_vec][8], vec[num_vec][9], vec[num_vec][10], vec[num_vec][11],
					vec[num_vec][12], vec[num_vec][13], vec[num_vec][14], vec[num_vec][15],
					vec[num_vec][16], vec[num_vec][17], vec[num_vec][18], vec[num_vec][19],
					vec[num_vec][20], vec[num_vec][21], vec[num_vec][22]);
				// Comment lines do not scan
				if (n_read == NUM_FIELDS) begin
					num_vec++;
				end else if (n_read > 0) begin
					$display("Data line %0d holds %0d fields instead of %0d",
						num_vec, n_read, NUM_FIELDS);
					$display("SOME TESTS FAILED");
					$fatal(1, "malformed data line");
				end
				line_buf = '0;
			end
			$fclose(fd);
			if (num_vec == 0) begin
				$display("The data file holds no data lines");
				$display("SOME TESTS FAILED");
				$fatal(1, "empty data file");
			end
		end
	endtask

	task automatic apply_vector(input int i);
		reset           <= vec[i][0][0];
		bubble_i        <= vec[i][1][0];
		secure_mode_i   <= vec[i][2][0];
		misprediction_i <= vec[i][3][0];
		jump_i          <= vec[i][4][FETCH_WIDTH-1:0];
		jalr_i          <= vec[i][5][FETCH_WIDTH-1:0];
		for (int k = 0; k < FETCH_WIDTH; k++) begin
			imm_i[k] <= vec[i][F_IMM + k];
		end
		pred_valid_i    <= vec[i][11][0];
		pred_target_i   <= vec[i][12];
		correct_pc_i    <= vec[i][13];
		inject_i        <= vec[i][14][0];
		inject_sel_i    <= vec[i][15][1:0];
		inject_mask_i   <= vec[i][16];
		clear_i         <= vec[i][17][0];
	endtask

	task automatic check_vector(input int i);
		pc_t exp_pc;
		pc_t exp_slot;
		pc_t exp_save;
		exp_pc = vec[i][F_EXP + 1];
		for (int k = 0; k < FETCH_WIDTH; k++) begin
			// Secure mode runs one PC in every slot
			exp_slot = vec[i][2][0] ? exp_pc : exp_pc + pc_t'(4 * k);
			// Link value for jal/jalr and auipc value otherwise
			if (vec[i][4][k] || vec[i][5][k]) begin
				exp_save = exp_pc + pc_t'(4 * (k + 1));
			end else begin
				exp_save = exp_slot + (vec[i][F_IMM + k] & 32'hFFFF_FFFC);
			end
			check_pc($sformatf("inst_addr_o[%0d]", k),
				vec[i][F_EXP] + pc_t'(4 * k), inst_addr_o[k]);
			check_pc($sformatf("current_pc_o[%0d]", k), exp_slot, current_pc_o[k]);
			check_pc($sformatf("pc_save_o[%0d]", k), exp_save, pc_save_o[k]);
		end
		check_mask("sticky_error_o", vec[i][F_EXP + 2][NUM_REPLICAS-1:0], sticky_error_o);
		check_flag("sticky_fatal_o", vec[i][F_EXP + 3][0], sticky_fatal_o);
		check_count("correction_count_o", vec[i][F_EXP + 4][CORR_CNT_W-1:0],
			correction_count_o);
	endtask

	initial begin
		vec_ready       = 1'b0;
		reset           = 1'b0;
		bubble_i        = 1'b0;
		secure_mode_i   = 1'b0;
		misprediction_i = 1'b0;
		jump_i          = '0;
		jalr_i          = '0;
		for (int k = 0; k < FETCH_WIDTH; k++) begin
			imm_i[k] = '0;
		end
		pred_valid_i    = 1'b0;
		pred_target_i   = '0;
		correct_pc_i    = '0;
		inject_i        = 1'b0;
		inject_sel_i    = '0;
		inject_mask_i   = '0;
		clear_i         = 1'b0;
		load_vectors();
		vec_ready = 1'b1;
		// Drive on the rising edge and sample half a period later
		for (int i = 0; i < num_vec; i++) begin
			@(posedge clk);
			apply_vector(i);
			@(negedge clk);
			check_vector(i);
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/fetch_pc_testdata.txt ====
# rst bub sec mis jmp jalr imm0 imm1 imm2 imm3 imm4 pv pred_tgt corr_pc inj sel mask clr
# then expected: addr0 slot0_pc sticky_err sticky_fatal corr_count
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 80000000 80000000 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 80000000 80000000 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 80000000 80000000 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 80000000 80000000 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 80000014 80000000 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 80000028 80000014 0 0 0
1 0 0 0 04 08 10 20 103 30 41 0 0 0 0 0 0 0 80000130 80000028 0 0 0
1 0 0 0 08 02 0 0 0 40 0 1 80004000 0 0 0 0 0 80004000 80000130 0 0 0
1 0 0 0 10 01 0 0 0 0 8 0 12345678 0 0 0 0 0 80004004 80004000 0 0 0
1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 80004004 80004004 0 0 0
1 1 0 1 01 0 100 0 0 0 0 0 0 80010000 0 0 0 0 80010000 80004004 0 0 0
1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 80010000 80010000 0 0 0
1 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 80010014 80010000 0 0 0
1 0 1 0 0 0 0 0 0 0 0 0 0 0 1 1 100 0 80010028 80010014 0 0 0
1 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8001003c 80010028 0 0 0
1 1 1 0 0 0 0 0 0 0 0 0 0 0 1 0 1 0 8001003c 8001003c 2 0 1
1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8001003c 8001003c 2 0 1
1 1 0 0 0 0 0 0 0 0 0 0 0 0 1 0 1 0 8001003c 8001003c 3 0 2
1 1 0 0 0 0 0 0 0 0 0 0 0 0 1 1 2 0 8001003d 8001003d 3 0 2
1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8001003c 8001003c 3 0 2
1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8001003c 8001003c 3 1 3
1 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 80010050 8001003c 3 1 3
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 80010064 80010050 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 80010078 80010064 0 0 0

// ==== tb.f ====
design/fetch_pkg.sv
design/tmr_voter.sv
design/pc_target_select.sv
design/pc_ctrl_super.sv
design/tmr_fault_monitor.sv
design/fetch_pc_unit.sv
sim/tb_fetch_pc.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_fetch_pc -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vtb_fetch_pc
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit 1
fi

exit 0
